//--- flist.f
+incdir+src
src/er_pkg.sv
src/pix_if.sv
src/cmd_fetch.sv
src/span_gen.sv
src/draw_engine.sv
src/vram_writer.sv
src/earthrise_top.sv
tb/earthrise_chk.sv
tb/vram_monitor.sv
tb/tb_earthrise.sv

//--- Makefile
SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv)

obj_dir/Vtb_earthrise: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_earthrise -f flist.f

run: obj_dir/Vtb_earthrise
	./obj_dir/Vtb_earthrise | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- tb/tb_earthrise.sv
// ##################################################
// testbench top: clock, reset, command memory,
// hand assembled programs, watchdog, final verdict
// ##################################################

`timescale 1ns/100ps

module tb_earthrise import er_pkg::*; ();

    localparam int NPROG = 12;

    logic   clk, rst, start;
    coord_t canv_w, canv_h;
    bpp_t   canv_bpp;
    vaddr_t addr_base, vram_addr;
    pc_t    pc;
    word_t  cmd_list, vram_din, vram_wmask;
    logic   busy, done, instr_invalid;
    word_t  cmd_mem [256];
    int     n_instr, ctl_err, seed;
    colr_t  c, fa, fb;
    bpp_t   bpp_list [5] = '{5'd1, 5'd2, 5'd4, 5'd8, 5'd3};

    assign cmd_list = cmd_mem[pc[9:2]];  // served combinationally

    earthrise_top DUT (.*);

    vram_monitor mon (.clk(clk), .canv_w(canv_w), .canv_h(canv_h), .canv_bpp(canv_bpp),
        .addr_base(addr_base), .done(done), .vram_addr(vram_addr), .vram_din(vram_din),
        .vram_wmask(vram_wmask));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(NPROG * 2000 * 20);
        $display("timeout, the engine never finished its programs");
        $display("Testbench failed");
        $finish;
    end

    function automatic colr_t rnd_colr();
        return colr_t'($random(seed)) | 8'h01;  // never background
    endfunction

    task automatic emit(input logic [3:0] opc, input logic [11:0] imm);
        if (n_instr[0]) cmd_mem[n_instr >> 1][31:16] = {opc, imm};
        else cmd_mem[n_instr >> 1][15:0] = {opc, imm};
        n_instr++;
    endtask

    task automatic vert(input int x, input int y);
        emit(4'h0, x[11:0]);
        emit(4'h1, y[11:0]);
    endtask

    task automatic new_prog(input bpp_t bpp);
        for (int i = 0; i < 256; i++) cmd_mem[i] = 32'hCC00_CC00;  // nop pairs
        n_instr = 0;
        mon.clear_all();
        @(posedge clk);
        canv_bpp <= bpp;
        emit(4'h8, 12'd0);  // translation back to zero
        emit(4'h9, 12'd0);
    endtask

    task automatic run_prog(input logic exp_inv);
        int chk0;
        @(posedge clk) start <= 1'b1;
        @(posedge clk) start <= 1'b0;
        @(negedge clk);
        if (!busy || instr_invalid) begin
            ctl_err++;
            $display("busy did not rise, or the invalid flag stayed set after start");
        end
        while (!done) @(negedge clk);
        if (instr_invalid !== exp_inv) begin
            ctl_err++;
            $display("[FAIL] instr_invalid: got %h, expected %h", instr_invalid, exp_inv);
        end
        chk0 = mon.check_cnt;
        while (mon.check_cnt == chk0) @(negedge clk);
        // engine back in idle with the pc cleared
        if (busy !== 1'b0) begin
            ctl_err++;
            $display("[FAIL] busy: got %h, expected %h", busy, 1'b0);
        end
        if (pc !== '0) begin
            ctl_err++;
            $display("[FAIL] pc: got %h, expected %h", pc, 10'h000);
        end
    endtask

    initial begin
        seed = 17;
        ctl_err = 0;
        rst = 1'b1;
        start = 1'b0;
        canv_w = 12'd16;
        canv_h = 12'd8;
        canv_bpp = 5'd4;
        addr_base = 16'h0100;
        for (int i = 0; i < 256; i++) cmd_mem[i] = 32'hCC00_CC00;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < 5; k++) begin  // one translated pixel per depth
            c = rnd_colr();
            new_prog(bpp_list[k]);
            emit(4'h8, 12'd3);
            emit(4'h9, 12'd2);
            emit(4'hC, {4'h0, c});
            vert(4, 1);
            emit(4'hD, 12'h000);
            emit(4'hC, 12'hE00);
            mon.add_box(7, 3, 7, 3, c);
            run_prog(1'b0);
        end
        c = rnd_colr();  // clipping, colour b
        new_prog(5'd4);
        emit(4'hC, {4'h1, c});
        vert(-1, 2);
        emit(4'hD, 12'h002);
        vert(16, 2);
        emit(4'hD, 12'h002);
        vert(-3, 5);
        emit(4'h2, 12'd4);
        emit(4'hD, 12'hF02);
        vert(0, -1);
        emit(4'h2, 12'd5);
        emit(4'hD, 12'hF02);
        vert(12, 7);
        emit(4'h2, 12'd20);
        emit(4'hD, 12'hF02);
        emit(4'hC, 12'hE00);
        mon.add_box(-3, 5, 4, 5, c);
        mon.add_box(12, 7, 20, 7, c);
        run_prog(1'b0);
        fa = rnd_colr();  // reversed rectangle, reversed span
        fb = rnd_colr();
        new_prog(5'd8);
        emit(4'hC, {4'h2, fa});
        emit(4'hC, {4'h3, fb});
        vert(10, 6);
        emit(4'h2, 12'd2);
        emit(4'h3, 12'd1);
        emit(4'hD, 12'h403);
        vert(9, 7);
        emit(4'h2, 12'd3);
        emit(4'hD, 12'hF00);
        emit(4'hC, 12'hE00);
        mon.add_box(2, 1, 10, 6, fb);
        run_prog(1'b0);
        c = rnd_colr();  // jump over a pixel, stop before another
        new_prog(5'd2);
        emit(4'hC, {4'h0, c});
        vert(1, 1);
        emit(4'hA, 12'd18);  // byte address of instruction 9
        emit(4'hC, 12'hA00);
        emit(4'hD, 12'h000);
        emit(4'h0, 12'd3);
        emit(4'h0, 12'd5);
        emit(4'hD, 12'h000);
        emit(4'hC, 12'hE00);
        emit(4'h0, 12'd6);
        emit(4'hD, 12'h000);
        mon.add_box(5, 1, 5, 1, c);
        run_prog(1'b0);
        c = rnd_colr();  // no stop, runs off the list
        new_prog(5'd4);
        emit(4'hC, {4'h0, c});
        vert(0, 0);
        emit(4'hD, 12'h000);
        mon.add_box(0, 0, 0, 0, c);
        run_prog(1'b0);
        c = rnd_colr();  // invalid opcode
        new_prog(5'd4);
        emit(4'hC, {4'h0, c});
        vert(2, 2);
        emit(4'hD, 12'h000);
        emit(4'h5, 12'h000);
        vert(3, 3);
        emit(4'hD, 12'h000);
        mon.add_box(2, 2, 2, 2, c);
        run_prog(1'b1);
        new_prog(5'd4);  // circle is gone
        vert(4, 4);
        emit(4'hD, 12'h100);
        emit(4'hD, 12'h000);
        run_prog(1'b1);
        c = rnd_colr();  // flag clears on the next run
        new_prog(5'd1);
        emit(4'hC, {4'h0, c});
        vert(15, 7);
        emit(4'hD, 12'h000);
        emit(4'hC, 12'hE00);
        mon.add_box(15, 7, 15, 7, c);
        run_prog(1'b0);
        $display("pixel errors %0d, control errors %0d, assertion errors %0d",
                 mon.err_count, ctl_err, DUT.u_chk.fail_cnt);
        if (mon.err_count == 0 && ctl_err == 0 && DUT.u_chk.fail_cnt == 0
                && mon.check_cnt == NPROG) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb/vram_monitor.sv
// ##################################################
// shadow vram, expected pixel model, canvas compare
// ##################################################

`timescale 1ns/100ps

module vram_monitor import er_pkg::*; (
    input logic   clk,
    input coord_t canv_w,
    input coord_t canv_h,
    input bpp_t   canv_bpp,
    input vaddr_t addr_base,
    input logic   done,
    input vaddr_t vram_addr,
    input word_t  vram_din,
    input word_t  vram_wmask
);

    word_t shadow [int];
    int    bx0 [$], by0 [$], bx1 [$], by1 [$];
    colr_t bc [$];
    int    err_count = 0;
    int    check_cnt = 0;
    int    settle = 0;  // cycles left until compare

    function automatic int eff_bpp();
        if (canv_bpp == 1 || canv_bpp == 2 || canv_bpp == 4 || canv_bpp == 8) return canv_bpp;
        return 4;  // unsupported depth
    endfunction

    // vram words covered by the canvas
    function automatic int canvas_words();
        return (int'(canv_w) * int'(canv_h) * eff_bpp() + 31) / 32;
    endfunction

    // expected colour bits of one pixel, last shape wins
    function automatic word_t expected_pixel(input int x, input int y);
        word_t v;
        v = '0;
        for (int i = 0; i < bc.size(); i++) begin
            if (x >= bx0[i] && x <= bx1[i] && y >= by0[i] && y <= by1[i]) v = bc[i];
        end
        return v & ((word_t'(1) << eff_bpp()) - 1);
    endfunction

    task automatic clear_all();
        shadow.delete();
        bx0.delete();
        by0.delete();
        bx1.delete();
        by1.delete();
        bc.delete();
    endtask

    task automatic add_box(input int x0, input int y0, input int x1, input int y1,
                           input colr_t c);
        bx0.push_back(x0);
        by0.push_back(y0);
        bx1.push_back(x1);
        by1.push_back(y1);
        bc.push_back(c);
    endtask

    task automatic compare_canvas();
        int    bo, addr;
        word_t w, got, exp;
        for (int y = 0; y < int'(canv_h); y++) begin
            for (int x = 0; x < int'(canv_w); x++) begin
                bo   = (y * int'(canv_w) + x) * eff_bpp();
                addr = int'(vaddr_t'(int'(addr_base) + bo / 32));
                w    = shadow.exists(addr) ? shadow[addr] : '0;
                got  = (w >> (bo % 32)) & ((word_t'(1) << eff_bpp()) - 1);
                exp  = expected_pixel(x, y);
                if (got !== exp) begin
                    err_count++;
                    $display(
                        "[FAIL] vram_din at pixel (%0d,%0d) vram_addr %h: got %h, expected %h",
                        x, y, addr[15:0], got, exp);
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (vram_wmask != '0) begin
            // clipped pixels must never reach vram
            if (int'(vram_addr) < int'(addr_base)
                    || int'(vram_addr) >= int'(addr_base) + canvas_words()) begin
                err_count++;
                $display(
                    "[FAIL] vram_wmask at vram_addr %h off the canvas: got %h, expected %h",
                    vram_addr, vram_wmask, 32'h0);
            end
            if (!shadow.exists(int'(vram_addr))) shadow[int'(vram_addr)] = '0;
            shadow[int'(vram_addr)] = (shadow[int'(vram_addr)] & ~vram_wmask)
                                    | (vram_din & vram_wmask);
        end
        if (settle > 0) begin
            settle--;
            if (settle == 0) begin
                compare_canvas();
                check_cnt++;
            end
        end
        if (done) settle = 2;  // writes trail done by 2 cycles
    end

endmodule

//--- tb/earthrise_chk.sv
// ##################################################
// top level protocol assertions, bound to the DUT
// ##################################################

`timescale 1ns/100ps

module earthrise_chk (
    input logic        clk,
    input logic        rst,
    input logic        start,
    input logic        busy,
    input logic        done,
    input logic [31:0] vram_wmask
);

    int fail_cnt = 0;  // failed assertions so far

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fail_cnt++;
        end

    busy_rise: assert property (@(posedge clk) disable iff (rst) start && !busy |=> busy)
        else begin
            $error("busy did not follow start");
            fail_cnt++;
        end

    // writes may trail done by two cycles
    quiet_mask: assert property (@(posedge clk) disable iff (rst)
        !busy && !$past(done) && !$past(done, 2) |-> vram_wmask == '0)
        else begin
            $error("vram write while idle");
            fail_cnt++;
        end

endmodule

bind earthrise_top earthrise_chk u_chk (
    .clk(clk), .rst(rst), .start(start), .busy(busy), .done(done), .vram_wmask(vram_wmask)
);

//--- src/earthrise_top.sv
// ##################################################
// graphics engine top level
// command fetch, draw engine, vram writer
// ##################################################

`timescale 1ns/100ps

module earthrise_top import er_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  coord_t canv_w,
    input  coord_t canv_h,
    input  bpp_t   canv_bpp,
    input  word_t  cmd_list,
    input  vaddr_t addr_base,
    output pc_t    pc,
    output vaddr_t vram_addr,
    output word_t  vram_din,
    output word_t  vram_wmask,
    output logic   busy,
    output logic   done,
    output logic   instr_invalid
);

    logic   advance, jump, restart, pc_end;
    pc_t    jump_addr;
    instr_t instr;

    pix_if pix ();

    cmd_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .cmd_list  (cmd_list),
        .advance   (advance),
        .jump      (jump),
        .jump_addr (jump_addr),
        .restart   (restart),
        .pc        (pc),
        .instr     (instr),
        .pc_end    (pc_end)
    );

    draw_engine u_engine (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .instr         (instr),
        .pc_end        (pc_end),
        .advance       (advance),
        .jump          (jump),
        .jump_addr     (jump_addr),
        .restart       (restart),
        .busy          (busy),
        .done          (done),
        .instr_invalid (instr_invalid),
        .pix           (pix.src)
    );

    vram_writer u_writer (
        .clk        (clk),
        .rst        (rst),
        .canv_w     (canv_w),
        .canv_h     (canv_h),
        .canv_bpp   (canv_bpp),
        .addr_base  (addr_base),
        .pix        (pix.dst),
        .vram_addr  (vram_addr),
        .vram_din   (vram_din),
        .vram_wmask (vram_wmask)
    );

endmodule

//--- src/vram_writer.sv
// ##################################################
// vram writer: canvas clip, packed pixel address
// latency matched write mask and data
// ##################################################

`timescale 1ns/100ps

`include "er_macros.svh"

module vram_writer import er_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  coord_t canv_w,
    input  coord_t canv_h,
    input  bpp_t   canv_bpp,
    input  vaddr_t addr_base,
    pix_if.dst     pix,
    output vaddr_t vram_addr,
    output word_t  vram_din,
    output word_t  vram_wmask
);

    localparam int LAT  = `ER_ADDR_LAT;
    localparam int IDXW = 2 * `ER_CORDW;

    logic [LAT-1:0]  we_sr;          // delayed pixel strobe
    colr_t           colr_sr [LAT];
    logic            clip_s1, clip_s2;
    logic [IDXW-1:0] idx_s1;         // y * width + x
    logic [IDXW+3:0] bit_off;
    logic [4:0]      shift_s2;       // pixel id * bpp
    logic [3:0]      bpp_eff;
    word_t           ones;

    always_comb begin
        case (canv_bpp)
            5'd1:    bpp_eff = 4'd1;
            5'd2:    bpp_eff = 4'd2;
            5'd4:    bpp_eff = 4'd4;
            5'd8:    bpp_eff = 4'd8;
            default: bpp_eff = 4'd4;  // unsupported depth
        endcase
    end

    assign bit_off = {4'd0, idx_s1} * {{IDXW{1'b0}}, bpp_eff};
    assign ones    = (word_t'(1) << bpp_eff) - word_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            we_sr <= '0;
        end else begin
            we_sr <= {we_sr[LAT-2:0], pix.drawing};
        end
    end

    always_ff @(posedge clk) begin
        colr_sr[0] <= pix.colr;
        for (int i = 1; i < LAT; i++) begin
            colr_sr[i] <= colr_sr[i-1];
        end
        // stage 1
        clip_s1 <= pix.x < 0 || pix.y < 0 || pix.x >= canv_w || pix.y >= canv_h;
        idx_s1  <= {{`ER_CORDW{1'b0}}, pix.y} * {{`ER_CORDW{1'b0}}, canv_w}
                 + {{`ER_CORDW{1'b0}}, pix.x};
        // stage 2
        clip_s2   <= clip_s1;
        shift_s2  <= bit_off[4:0];  // bit offset mod 32
        vram_addr <= addr_base + bit_off[`ER_VADDRW+4:5];
    end

    always_comb begin
        if (we_sr[LAT-1] && !clip_s2) begin
            vram_wmask = ones << shift_s2;
        end else begin
            vram_wmask = '0;
        end
        vram_din = (word_t'(colr_sr[LAT-1]) & ones) << shift_s2;
    end

endmodule

//--- src/draw_engine.sv
// ##################################################
// execution FSM, vertex and colour registers
// pixel, span and filled rectangle sequencing
// ##################################################

`timescale 1ns/100ps

`include "er_macros.svh"

module draw_engine import er_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  instr_t instr,
    input  logic   pc_end,
    output logic   advance,
    output logic   jump,
    output pc_t    jump_addr,
    output logic   restart,
    output logic   busy,
    output logic   done,
    output logic   instr_invalid,
    pix_if.src     pix
);

    eng_state_e state;
    opcode_e    opc;
    coord_t     imm12;
    colr_t      imm8;       // colour or draw options
    ctrl_fun_e  cfun;
    draw_fun_e  dfun;
    coord_t     tvx0, tvy0, tvx1, tvy1;  // translated vertices
    coord_t     xt, yt;
    colr_t      lca, lcb, fca, fcb;
    pc_t        jaddr;
    coord_t     rx0, rx1, ry1;  // sorted rectangle corners
    coord_t     rect_y;         // current rectangle row
    logic       sg_start, sg_valid, sg_done;
    coord_t     sg_x0, sg_x1, sg_x;

    assign imm8 = imm12[7:0];
    assign cfun = ctrl_fun_e'(imm12[11:8]);
    assign dfun = draw_fun_e'(imm12[11:8]);

    assign advance   = state == DECODE && !pc_end;
    assign jump      = state == EXEC && opc == CTRL && cfun == JUMP;
    assign jump_addr = jaddr;
    assign restart   = state == DONE;
    assign done      = state == DONE;

    // span starts straight from EXEC, rect rows from RECT_ROW
    assign sg_start = (state == EXEC && opc == DRAW && dfun == SPAN) || state == RECT_ROW;
    assign sg_x0    = (state == RECT_ROW) ? rx0 : tvx0;
    assign sg_x1    = (state == RECT_ROW) ? rx1 : tvx1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            busy          <= 1'b0;
            instr_invalid <= 1'b0;
            pix.drawing   <= 1'b0;
            {lca, lcb, fca, fcb} <= {4{colr_t'(1)}};
            xt            <= '0;
            yt            <= '0;
            jaddr         <= '0;
        end else begin
            pix.drawing <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state         <= FETCH;
                    busy          <= 1'b1;
                    instr_invalid <= 1'b0;
                end
                FETCH: state <= DECODE;
                JUMP_WAIT: state <= FETCH;  // pc settles after the jump
                DECODE: begin
                    if (pc_end) begin
                        state <= DONE;  // ran off the end of the list
                    end else begin
                        state <= EXEC;
                        opc   <= opcode_e'(instr[15:12]);
                        imm12 <= instr[11:0];
                    end
                end
                EXEC: begin
                    state <= FETCH;
                    case (opc)
                        VX0:  tvx0  <= imm12 + xt;
                        VY0:  tvy0  <= imm12 + yt;
                        VX1:  tvx1  <= imm12 + xt;
                        VY1:  tvy1  <= imm12 + yt;
                        XT:   xt    <= imm12;
                        YT:   yt    <= imm12;
                        SETJ: jaddr <= imm12[`ER_PCW-1:0];
                        CTRL: begin
                            case (cfun)
                                LCA:  lca   <= imm8;
                                LCB:  lcb   <= imm8;
                                FCA:  fca   <= imm8;
                                FCB:  fcb   <= imm8;
                                JUMP: state <= JUMP_WAIT;
                                NOP:  state <= FETCH;
                                STOP: state <= DONE;
                                default: begin
                                    state         <= DONE;
                                    instr_invalid <= 1'b1;
                                end
                            endcase
                        end
                        DRAW: begin
                            // bit 0 picks fill, bit 1 picks colour b
                            pix.colr <= imm8[0] ? (imm8[1] ? fcb : fca) : (imm8[1] ? lcb : lca);
                            case (dfun)
                                PIXEL: begin
                                    pix.x       <= tvx0;
                                    pix.y       <= tvy0;
                                    pix.drawing <= 1'b1;
                                end
                                SPAN: begin
                                    pix.y <= tvy0;
                                    state <= SPAN_RUN;
                                end
                                RECT: begin
                                    rx0    <= (tvx0 < tvx1) ? tvx0 : tvx1;
                                    rx1    <= (tvx0 < tvx1) ? tvx1 : tvx0;
                                    rect_y <= (tvy0 < tvy1) ? tvy0 : tvy1;
                                    ry1    <= (tvy0 < tvy1) ? tvy1 : tvy0;
                                    state  <= RECT_ROW;
                                end
                                default: begin
                                    state         <= DONE;
                                    instr_invalid <= 1'b1;
                                end
                            endcase
                        end
                        default: begin
                            state         <= DONE;
                            instr_invalid <= 1'b1;
                        end
                    endcase
                end
                SPAN_RUN: begin
                    pix.drawing <= sg_valid;
                    pix.x       <= sg_x;
                    if (sg_done) state <= DECODE;  // pc already points past it
                end
                RECT_ROW: begin
                    pix.y <= rect_y;  // last pixel of the previous row leaves this cycle
                    state <= RECT_RUN;
                end
                RECT_RUN: begin
                    pix.drawing <= sg_valid;
                    pix.x       <= sg_x;
                    if (sg_done) begin
                        if (rect_y == ry1) begin
                            state <= DECODE;
                        end else begin
                            rect_y <= rect_y + coord_t'(1);
                            state  <= RECT_ROW;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                    busy  <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    span_gen u_span (
        .clk   (clk),
        .rst   (rst),
        .start (sg_start),
        .x0    (sg_x0),
        .x1    (sg_x1),
        .x     (sg_x),
        .valid (sg_valid),
        .done  (sg_done)
    );

endmodule

//--- src/span_gen.sv
// ##################################################
// horizontal span stepper, one x per cycle
// ##################################################

`timescale 1ns/100ps

module span_gen import er_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  coord_t x0,
    input  coord_t x1,
    output coord_t x,
    output logic   valid,
    output logic   done
);

    coord_t x_end;
    coord_t x_nxt;
    logic   active;  // more pixels to come

    assign x_nxt = x + coord_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            valid  <= 1'b0;
            done   <= 1'b0;
        end else if (start) begin
            active <= x0 < x1;
            valid  <= x0 <= x1;  // reversed span gives a bare done
            done   <= x0 >= x1;
        end else if (active) begin
            active <= x_nxt != x_end;
            valid  <= 1'b1;
            done   <= x_nxt == x_end;
        end else begin
            valid <= 1'b0;
            done  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x     <= x0;
            x_end <= x1;
        end else if (active) begin
            x <= x_nxt;
        end
    end

endmodule

//--- src/cmd_fetch.sv
// ##################################################
// command list fetch
// program counter with overflow bit, jump, restart
// ##################################################

`timescale 1ns/100ps

`include "er_macros.svh"

module cmd_fetch import er_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  word_t  cmd_list,
    input  logic   advance,
    input  logic   jump,
    input  pc_t    jump_addr,
    input  logic   restart,
    output pc_t    pc,
    output instr_t instr,
    output logic   pc_end
);

    logic [`ER_PCW:0] pc_reg;  // msb flags list overflow

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_reg <= '0;
        end else if (restart) begin
            pc_reg <= '0;  // every run starts at address 0
        end else if (jump) begin
            pc_reg <= {1'b0, jump_addr};
        end else if (advance) begin
            pc_reg <= pc_reg + 2'd2;  // 16-bit instructions
        end
    end

    assign pc     = pc_reg[`ER_PCW-1:0];
    assign pc_end = pc_reg[`ER_PCW];

    // two instructions per word, pc bit 1 picks the half
    assign instr = pc[1] ? cmd_list[`ER_WORD-1:`ER_WORD/2] : cmd_list[`ER_WORD/2-1:0];

endmodule

//--- src/pix_if.sv
// ##################################################
// pixel stream from draw engine to vram writer
// ##################################################

`timescale 1ns/100ps

interface pix_if import er_pkg::*; ();

    logic   drawing;  // one strobe per pixel
    coord_t x;
    coord_t y;
    colr_t  colr;

    modport src (output drawing, x, y, colr);
    modport dst (input drawing, x, y, colr);

endinterface

//--- src/er_pkg.sv
// ##################################################
// shared data types for the graphics engine
// opcode, function and engine state enums
// ##################################################

`include "er_macros.svh"

package er_pkg;

    typedef logic signed [`ER_CORDW-1:0] coord_t;
    typedef logic [`ER_COLRW-1:0]        colr_t;
    typedef logic [`ER_WORD-1:0]         word_t;
    typedef logic [`ER_VADDRW-1:0]       vaddr_t;
    typedef logic [`ER_PCW-1:0]          pc_t;   // byte address
    typedef logic [15:0]                 instr_t;
    typedef logic [4:0]                  bpp_t;

    typedef enum logic [3:0] {
        VX0 = 4'h0, VY0 = 4'h1, VX1 = 4'h2, VY1 = 4'h3,
        XT = 4'h8, YT = 4'h9, SETJ = 4'hA, CTRL = 4'hC, DRAW = 4'hD
    } opcode_e;

    typedef enum logic [3:0] {
        LCA = 4'h0, LCB = 4'h1, FCA = 4'h2, FCB = 4'h3,
        JUMP = 4'hA, NOP = 4'hC, STOP = 4'hE
    } ctrl_fun_e;

    typedef enum logic [3:0] {PIXEL = 4'h0, RECT = 4'h4, SPAN = 4'hF} draw_fun_e;

    typedef enum logic [3:0] {
        IDLE, FETCH, DECODE, EXEC, DONE, SPAN_RUN, RECT_ROW, RECT_RUN, JUMP_WAIT
    } eng_state_e;

endpackage

//--- src/er_macros.svh
// ##################################################
// width and latency macros for the graphics engine
// ##################################################

`ifndef ER_MACROS_SVH
`define ER_MACROS_SVH

`define ER_CORDW    12  // signed coordinate width
`define ER_WORD     32  // vram and command word
`define ER_COLRW    8   // colour width
`define ER_VADDRW   16  // vram word address
`define ER_PCW      10  // command list byte address

// pixel strobe to vram write strobe
`define ER_ADDR_LAT 2

`endif
